// File: src/fp16_settings.svh
// --------------------------------------------------
// FP16 adder settings
// Format widths, bias and internal datapath widths
// --------------------------------------------------
`ifndef FP16_SETTINGS_SVH
`define FP16_SETTINGS_SVH

// binary16 field widths and exponent bias
`define FP16_EXP_BITS 5
`define FP16_MAN_BITS 10
`define FP16_BIAS 15

// Precision p, implicit bit included
`define FP16_PREC_BITS 11

// Internal sum is 3p+4 bits, the LZC searches the lower 2p+3
`define FP16_SUM_WIDTH 37
`define FP16_LOWER_SUM_WIDTH 25

// Signed internal exponent and shift amount widths
`define FP16_EXP_WIDTH 7
`define FP16_SHAMT_WIDTH 6

`endif

// File: src/fp16_pkg.sv
// --------------------------------------------------
// FP16 adder types
// --------------------------------------------------
`include "fp16_settings.svh"
`default_nettype none

package fp16_pkg;

  // Packed binary16 value
  typedef struct packed {
    logic                      sign;
    logic [`FP16_EXP_BITS-1:0] exponent;
    logic [`FP16_MAN_BITS-1:0] mantissa;
  } fp16_t;

  // Operand class bits
  typedef struct packed {
    logic is_normal;
    logic is_subnormal;
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
    logic is_quiet;
  } fp_info_t;

  // RISC-V rounding mode encoding
  typedef enum logic [2:0] {
    RNE = 3'd0,
    RTZ = 3'd1,
    RDN = 3'd2,
    RUP = 3'd3,
    RMM = 3'd4
  } roundmode_e;

  // Exception flags, no DZ in an adder
  typedef struct packed {
    logic nv;
    logic of;
    logic uf;
    logic nx;
  } status_t;

  typedef logic signed [`FP16_EXP_WIDTH-1:0] exp_t;
  typedef logic [`FP16_SHAMT_WIDTH-1:0] shamt_t;
  typedef logic [`FP16_SUM_WIDTH-1:0] sum_t;

  // Contents of the register after the adder
  typedef struct packed {
    logic       eff_sub;
    exp_t       exp_prod;
    exp_t       exp_diff;
    exp_t       tent_exp;
    shamt_t     addend_shamt;
    logic       sticky;
    sum_t       sum;
    logic       final_sign;
    roundmode_e rnd_mode;
    logic       is_special;
    fp16_t      special_result;
    status_t    special_status;
  } mid_stage_t;

endpackage

`default_nettype wire

// File: src/fp16_classifier.sv
// --------------------------------------------------
// FP16 classifier
// Decodes one binary16 operand into its class bits
// --------------------------------------------------
`include "fp16_settings.svh"
`default_nettype none

module fp16_classifier (
  input  fp16_pkg::fp16_t    operand_i,
  output fp16_pkg::fp_info_t info_o
);

  logic exp_zero;
  logic exp_ones;
  logic man_zero;

  // Field decode
  assign exp_zero = (operand_i.exponent == '0);
  assign exp_ones = (operand_i.exponent == '1);
  assign man_zero = (operand_i.mantissa == '0);

  // Finite classes
  assign info_o.is_normal    = !exp_zero && !exp_ones;
  assign info_o.is_subnormal = exp_zero && !man_zero;
  assign info_o.is_zero      = exp_zero && man_zero;

  // All-ones exponent is inf or NaN
  assign info_o.is_inf = exp_ones && man_zero;
  assign info_o.is_nan = exp_ones && !man_zero;

  // Quiet bit is the top mantissa bit
  assign info_o.is_signalling = info_o.is_nan && !operand_i.mantissa[`FP16_MAN_BITS-1];
  assign info_o.is_quiet      = info_o.is_nan && operand_i.mantissa[`FP16_MAN_BITS-1];

endmodule

`default_nettype wire

// File: src/fp16_special_cases.sv
// --------------------------------------------------
// FP16 special cases
// Bypass result and flags for NaN and inf inputs
// --------------------------------------------------
`include "fp16_settings.svh"
`default_nettype none

module fp16_special_cases (
  input  fp16_pkg::fp16_t    a_i,
  input  fp16_pkg::fp16_t    b_i,
  input  fp16_pkg::fp_info_t a_info_i,
  input  fp16_pkg::fp_info_t b_info_i,
  input  logic               eff_sub_i,
  output fp16_pkg::fp16_t    result_o,
  output fp16_pkg::status_t  status_o,
  output logic               is_special_o
);

  import fp16_pkg::*;

  // Canonical quiet NaN, 0x7E00
  localparam fp16_t QNAN = '{
    sign:     1'b0,
    exponent: '1,
    mantissa: `FP16_MAN_BITS'(1 << (`FP16_MAN_BITS - 1))
  };

  always_comb begin
    result_o     = QNAN;
    status_o     = '0;
    is_special_o = 1'b0;
    if (a_info_i.is_nan || b_info_i.is_nan) begin
      // Any NaN gives qNaN, invalid only when signalling
      is_special_o = 1'b1;
      status_o.nv  = a_info_i.is_signalling || b_info_i.is_signalling;
    end else if (a_info_i.is_inf || b_info_i.is_inf) begin
      is_special_o = 1'b1;
      if (a_info_i.is_inf && b_info_i.is_inf && eff_sub_i) begin
        // inf - inf is invalid
        status_o.nv = 1'b1;
      end else if (a_info_i.is_inf) begin
        result_o = '{sign: a_i.sign, exponent: '1, mantissa: '0};
      end else begin
        result_o = '{sign: b_i.sign, exponent: '1, mantissa: '0};
      end
    end
  end

endmodule

`default_nettype wire

// File: src/fp16_align_add.sv
// --------------------------------------------------
// FP16 alignment and addition
// Exponent path, addend shift with sticky, 37-bit add
// --------------------------------------------------
`include "fp16_settings.svh"
`default_nettype none

module fp16_align_add (
  input  fp16_pkg::fp16_t    a_i,
  input  fp16_pkg::fp16_t    b_i,
  input  fp16_pkg::fp_info_t a_info_i,
  input  fp16_pkg::fp_info_t b_info_i,
  output logic               eff_sub_o,
  output fp16_pkg::exp_t     exp_prod_o,
  output fp16_pkg::exp_t     exp_diff_o,
  output fp16_pkg::exp_t     tent_exp_o,
  output fp16_pkg::shamt_t   addend_shamt_o,
  output logic               sticky_o,
  output fp16_pkg::sum_t     sum_o,
  output logic               final_sign_o
);

  import fp16_pkg::*;

  localparam int P = `FP16_PREC_BITS;
  localparam int SW = `FP16_SUM_WIDTH;

  exp_t                exp_a;
  exp_t                exp_addend;
  logic [P-1:0]        man_a;
  logic [P-1:0]        man_b;
  sum_t                prod_shifted;
  logic [SW+P-1:0]     addend_wide;
  sum_t                addend_aligned;
  sum_t                addend_inv;
  logic                inject_carry;
  logic [SW:0]         sum_raw;
  logic                sum_carry;

  // --------------------------------------------------
  // Exponent datapath
  // A is the product anchor (1.0 times A), B the addend
  assign eff_sub_o = a_i.sign ^ b_i.sign;
  assign exp_a     = exp_t'({2'b00, a_i.exponent});

  // Subnormals sit at biased exponent 1
  assign exp_addend = exp_t'({2'b00, b_i.exponent}) + exp_t'(!b_info_i.is_normal);
  // A zero anchor is placed at the minimum exponent
  assign exp_prod_o = a_info_i.is_zero ? exp_t'(2 - `FP16_BIAS)
                                       : exp_a + exp_t'(a_info_i.is_subnormal);
  assign exp_diff_o = exp_addend - exp_prod_o;
  assign tent_exp_o = (exp_diff_o > 0) ? exp_addend : exp_prod_o;

  // Saturated right shift of the addend
  always_comb begin
    if (exp_diff_o <= exp_t'(-2 * P - 1)) begin
      // Addend only reaches the sticky bit
      addend_shamt_o = shamt_t'(3 * P + 4);
    end else if (exp_diff_o <= exp_t'(P + 2)) begin
      addend_shamt_o = shamt_t'(exp_t'(P + 3) - exp_diff_o);
    end else begin
      // Anchor falls entirely below the addend
      addend_shamt_o = '0;
    end
  end

  // --------------------------------------------------
  // Mantissa datapath
  assign man_a = {a_info_i.is_normal, a_i.mantissa};
  assign man_b = {b_info_i.is_normal, b_i.mantissa};

  // Anchor sits p+2 bits below the top, with room for G and R
  assign prod_shifted = sum_t'(man_a) << (P + 1);

  // Up to p bits fall off the bottom into the sticky bit
  assign addend_wide    = {man_b, {SW{1'b0}}} >> addend_shamt_o;
  assign addend_aligned = addend_wide[SW+P-1:P];
  assign sticky_o       = |addend_wide[P-1:0];

  // Two's complement subtraction, carry only when nothing is sticky
  assign addend_inv   = eff_sub_o ? ~addend_aligned : addend_aligned;
  assign inject_carry = eff_sub_o && !sticky_o;

  assign sum_raw   = {1'b0, prod_shifted} + {1'b0, addend_inv} + (SW + 1)'(inject_carry);
  assign sum_carry = sum_raw[SW];

  // No carry on subtraction means a negative sum
  assign sum_o = (eff_sub_o && !sum_carry) ? sum_t'(-sum_raw) : sum_raw[SW-1:0];

  // Sign follows the anchor unless the subtraction flipped it
  assign final_sign_o = eff_sub_o ? (sum_carry == a_i.sign) : a_i.sign;

endmodule

`default_nettype wire

// File: src/fp16_normalize.sv
// --------------------------------------------------
// FP16 normalization
// LZC, normalization shift and one-bit fix
// --------------------------------------------------
`include "fp16_settings.svh"
`default_nettype none

module fp16_normalize (
  input  fp16_pkg::sum_t          sum_i,
  input  fp16_pkg::exp_t          exp_prod_i,
  input  fp16_pkg::exp_t          exp_diff_i,
  input  fp16_pkg::exp_t          tent_exp_i,
  input  fp16_pkg::shamt_t        addend_shamt_i,
  input  logic                    eff_sub_i,
  input  logic                    sticky_i,
  output fp16_pkg::exp_t          exponent_o,
  output logic [`FP16_PREC_BITS:0] mantissa_o,
  output logic                    sticky_o,
  output logic                    tiny_guard_o
);

  import fp16_pkg::*;

  localparam int P = `FP16_PREC_BITS;
  localparam int SW = `FP16_SUM_WIDTH;
  localparam int LW = `FP16_LOWER_SUM_WIDTH;

  logic [LW-1:0] sum_lower;
  shamt_t        lzc;
  logic          lzc_zeroes;
  exp_t          lzc_exp;
  exp_t          shifted_exp;
  shamt_t        norm_shamt;
  exp_t          norm_exp;
  logic [SW:0]   sum_shifted;
  logic [LW-1:0] sum_sticky_bits;

  // --------------------------------------------------
  // Leading-zero count on the lower 2p+3 bits
  assign sum_lower  = sum_i[LW-1:0];
  assign lzc_zeroes = ~|sum_lower;

  always_comb begin
    lzc = '0;
    // Highest set bit wins
    for (int i = 0; i < LW; i++) begin
      if (sum_lower[i]) begin
        lzc = shamt_t'(LW - 1 - i);
      end
    end
  end

  assign lzc_exp     = exp_t'({1'b0, lzc});
  assign shifted_exp = exp_prod_i - lzc_exp + exp_t'(1);

  // --------------------------------------------------
  // Normalization shift amount
  always_comb begin
    if ((exp_diff_i <= 0) || (eff_sub_i && (exp_diff_i <= 2))) begin
      if ((shifted_exp >= 0) && !lzc_zeroes) begin
        // Undo the anchor offset and drop the counted zeros
        norm_shamt = shamt_t'(P + 2) + lzc;
        norm_exp   = shifted_exp;
      end else begin
        // Subnormal result, stop at the minimum exponent
        norm_shamt = shamt_t'(exp_t'(P + 2) + exp_prod_i);
        norm_exp   = '0;
      end
    end else begin
      // Addend-anchored, undo the alignment shift
      norm_shamt = addend_shamt_i;
      norm_exp   = tent_exp_i;
    end
  end

  assign sum_shifted = {1'b0, sum_i} << norm_shamt;

  // One-bit fix, leading one may sit one place off
  always_comb begin
    {mantissa_o, sum_sticky_bits} = sum_shifted[SW-1:0];
    exponent_o                    = norm_exp;
    if (sum_shifted[SW]) begin
      // Carry out, shift right
      {mantissa_o, sum_sticky_bits} = sum_shifted[SW:1];
      exponent_o                    = norm_exp + exp_t'(1);
    end else if (sum_shifted[SW-1]) begin
      // Already normal
      exponent_o = norm_exp;
    end else if (norm_exp > 1) begin
      {mantissa_o, sum_sticky_bits} = {sum_shifted[SW-2:0], 1'b0};
      exponent_o                    = norm_exp - exp_t'(1);
    end else begin
      exponent_o = '0;
    end
  end

  assign sticky_o     = (|sum_sticky_bits) | sticky_i;
  // Top discarded bit, used for tininess after rounding
  assign tiny_guard_o = sum_sticky_bits[LW-1];

endmodule

`default_nettype wire

// File: src/fp16_round.sv
// --------------------------------------------------
// FP16 rounding
// Overflow saturation, rounding and status flags
// --------------------------------------------------
`include "fp16_settings.svh"
`default_nettype none

module fp16_round (
  input  logic                     sign_i,
  input  fp16_pkg::exp_t           exponent_i,
  input  logic [`FP16_PREC_BITS:0] mantissa_i,
  input  logic                     sticky_i,
  input  logic                     tiny_guard_i,
  input  fp16_pkg::roundmode_e     rnd_mode_i,
  input  logic                     eff_sub_i,
  output fp16_pkg::fp16_t          result_o,
  output fp16_pkg::status_t        status_o
);

  import fp16_pkg::*;

  localparam int EB = `FP16_EXP_BITS;
  localparam int MB = `FP16_MAN_BITS;

  logic              of_before;
  logic              of_after;
  logic              uf_after;
  logic [EB-1:0]     pre_exp;
  logic [EB+MB-1:0]  pre_abs;
  logic [1:0]        rs_bits;
  logic              round_up;
  logic [EB+MB-1:0]  rounded_abs;
  logic [EB-1:0]     rounded_exp;
  logic              exact_zero;

  // Exponent at or above all ones is an overflow
  assign of_before = exponent_i >= exp_t'((1 << EB) - 1);

  // Overflow saturates to the largest finite value
  assign pre_exp = of_before ? EB'((1 << EB) - 2) : exponent_i[EB-1:0];
  assign pre_abs = of_before ? {pre_exp, {MB{1'b1}}} : {pre_exp, mantissa_i[MB:1]};
  // Bit 0 of the mantissa is the round bit
  assign rs_bits = of_before ? 2'b11 : {mantissa_i[0], sticky_i};

  always_comb begin
    case (rnd_mode_i)
      RNE:     round_up = rs_bits[1] && (rs_bits[0] || pre_abs[0]);
      RTZ:     round_up = 1'b0;
      RDN:     round_up = (|rs_bits) && sign_i;
      RUP:     round_up = (|rs_bits) && !sign_i;
      RMM:     round_up = rs_bits[1];
      default: round_up = 1'b0;
    endcase
  end

  assign rounded_abs = pre_abs + (EB + MB)'(round_up);
  assign rounded_exp = rounded_abs[EB+MB-1:MB];

  // Exact zero from cancellation is +0, -0 only under RDN
  assign exact_zero      = (pre_abs == '0) && (rs_bits == 2'b00);
  assign result_o.sign   = (exact_zero && eff_sub_i) ? (rnd_mode_i == RDN) : sign_i;
  assign result_o.exponent = rounded_exp;
  assign result_o.mantissa = rounded_abs[MB-1:0];

  // --------------------------------------------------
  // Flags, tininess checked after rounding
  assign of_after = (rounded_exp == '1);
  assign uf_after = (rounded_exp == '0) ||
                    ((pre_exp == '0) && (rounded_exp == EB'(1)) &&
                     ((rs_bits != 2'b11) ||
                      (!tiny_guard_i && ((rnd_mode_i == RNE) || (rnd_mode_i == RMM)))));

  assign status_o.nv = 1'b0;
  assign status_o.of = of_before || of_after;
  assign status_o.nx = (|rs_bits) || of_before || of_after;
  // Only inexact tiny results underflow
  assign status_o.uf = uf_after && status_o.nx;

endmodule

`default_nettype wire

// File: src/fp16_adder.sv
// --------------------------------------------------
// FP16 adder top level
// Two-stage binary16 adder with status flags
// --------------------------------------------------
`include "fp16_settings.svh"
`default_nettype none

module fp16_adder (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 valid_i,
  input  fp16_pkg::fp16_t      operand_a_i,
  input  fp16_pkg::fp16_t      operand_b_i,
  input  fp16_pkg::roundmode_e rnd_mode_i,
  output logic                 valid_o,
  output fp16_pkg::fp16_t      result_o,
  output fp16_pkg::status_t    status_o
);

  import fp16_pkg::*;

  fp_info_t   a_info;
  fp_info_t   b_info;
  mid_stage_t mid_d;
  mid_stage_t mid_q;
  logic       mid_valid_q;
  exp_t       norm_exp;
  logic [`FP16_PREC_BITS:0] norm_man;
  logic       norm_sticky;
  logic       norm_tiny_guard;
  fp16_t      regular_result;
  status_t    regular_status;

  // --------------------------------------------------
  // First stage, classify, align and add
  fp16_classifier a_class_i (.operand_i(operand_a_i), .info_o(a_info));
  fp16_classifier b_class_i (.operand_i(operand_b_i), .info_o(b_info));

  fp16_align_add align_add_i (
    .a_i           (operand_a_i),
    .b_i           (operand_b_i),
    .a_info_i      (a_info),
    .b_info_i      (b_info),
    .eff_sub_o     (mid_d.eff_sub),
    .exp_prod_o    (mid_d.exp_prod),
    .exp_diff_o    (mid_d.exp_diff),
    .tent_exp_o    (mid_d.tent_exp),
    .addend_shamt_o(mid_d.addend_shamt),
    .sticky_o      (mid_d.sticky),
    .sum_o         (mid_d.sum),
    .final_sign_o  (mid_d.final_sign)
  );

  fp16_special_cases special_i (
    .a_i         (operand_a_i),
    .b_i         (operand_b_i),
    .a_info_i    (a_info),
    .b_info_i    (b_info),
    .eff_sub_i   (mid_d.eff_sub),
    .result_o    (mid_d.special_result),
    .status_o    (mid_d.special_status),
    .is_special_o(mid_d.is_special)
  );

  assign mid_d.rnd_mode = rnd_mode_i;

  // Mid-stage register, payload loads only with a valid input
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mid_valid_q <= 1'b0;
    end else begin
      mid_valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      mid_q <= mid_d;
    end
  end

  // --------------------------------------------------
  // Second stage, normalize and round
  fp16_normalize normalize_i (
    .sum_i         (mid_q.sum),
    .exp_prod_i    (mid_q.exp_prod),
    .exp_diff_i    (mid_q.exp_diff),
    .tent_exp_i    (mid_q.tent_exp),
    .addend_shamt_i(mid_q.addend_shamt),
    .eff_sub_i     (mid_q.eff_sub),
    .sticky_i      (mid_q.sticky),
    .exponent_o    (norm_exp),
    .mantissa_o    (norm_man),
    .sticky_o      (norm_sticky),
    .tiny_guard_o  (norm_tiny_guard)
  );

  fp16_round round_i (
    .sign_i      (mid_q.final_sign),
    .exponent_i  (norm_exp),
    .mantissa_i  (norm_man),
    .sticky_i    (norm_sticky),
    .tiny_guard_i(norm_tiny_guard),
    .rnd_mode_i  (mid_q.rnd_mode),
    .eff_sub_i   (mid_q.eff_sub),
    .result_o    (regular_result),
    .status_o    (regular_status)
  );

  // Output register, special bypass wins over the regular path
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_o  <= 1'b0;
      result_o <= '0;
      status_o <= '0;
    end else begin
      valid_o <= mid_valid_q;
      if (mid_valid_q) begin
        result_o <= mid_q.is_special ? mid_q.special_result : regular_result;
        status_o <= mid_q.is_special ? mid_q.special_status : regular_status;
      end
    end
  end

endmodule

`default_nettype wire

// File: bench/fp16_adder_tb.sv
// --------------------------------------------------
// FP16 adder testbench
// Table-driven sums, rounding, specials and latency
// --------------------------------------------------
`default_nettype none

module fp16_adder_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import fp16_pkg::*;

  localparam int CLK_PERIOD  = 4;
  localparam int LATENCY     = 2;
  localparam int NUM_TESTS   = 19;
  localparam int WATCHDOG_NS = NUM_TESTS * CLK_PERIOD + 100 * CLK_PERIOD;

  // Expected flag patterns, order is NV OF UF NX
  localparam status_t ST_NONE  = status_t'(4'b0000);
  localparam status_t ST_NX    = status_t'(4'b0001);
  localparam status_t ST_OF_NX = status_t'(4'b0101);
  localparam status_t ST_NV    = status_t'(4'b1000);

  typedef struct packed {
    fp16_t      a;
    fp16_t      b;
    roundmode_e mode;
    fp16_t      result;
    status_t    status;
  } test_vec_t;

  logic       clk_i;
  logic       rst_i;
  logic       valid_i;
  fp16_t      operand_a_i;
  fp16_t      operand_b_i;
  roundmode_e rnd_mode_i;
  logic       valid_o;
  fp16_t      result_o;
  status_t    status_o;

  test_vec_t tests [NUM_TESTS];
  int        num_loaded = 0;
  int        cycle_cnt = 0;
  int        done_cnt = 0;
  int        ok_cnt = 0;
  int        fail_cnt = 0;
  int        other_errors = 0;
  // Outstanding operations with their table index and the cycle that drove them
  int        pend_idx_q[$];
  int        pend_cycle_q[$];

  fp16_adder dut_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .valid_i    (valid_i),
    .operand_a_i(operand_a_i),
    .operand_b_i(operand_b_i),
    .rnd_mode_i (rnd_mode_i),
    .valid_o    (valid_o),
    .result_o   (result_o),
    .status_o   (status_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // Rising edge counter, used for the latency check
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // --------------------------------------------------
  // Table handling
  task automatic add_test(input fp16_t a, input fp16_t b, input roundmode_e mode,
                          input fp16_t result, input status_t status);
    tests[num_loaded] = '{a: a, b: b, mode: mode, result: result, status: status};
    num_loaded++;
  endtask

  task automatic load_table();
    // Exact sums, 1.5 + 2.25 = 3.75 and two smallest subnormals
    add_test(16'h3C00, 16'h3C00, RNE, 16'h4000, ST_NONE);
    add_test(16'h3E00, 16'h4080, RNE, 16'h4380, ST_NONE);
    add_test(16'h0001, 16'h0001, RNE, 16'h0002, ST_NONE);
    // 1 + 2^-11 is a tie halfway between 1.0 and its successor
    add_test(16'h3C00, 16'h1000, RNE, 16'h3C00, ST_NX);
    add_test(16'h3C00, 16'h1000, RTZ, 16'h3C00, ST_NX);
    add_test(16'h3C00, 16'h1000, RDN, 16'h3C00, ST_NX);
    add_test(16'h3C00, 16'h1000, RUP, 16'h3C01, ST_NX);
    add_test(16'h3C00, 16'h1000, RMM, 16'h3C01, ST_NX);
    // Exact cancellation, -0 only when rounding down
    add_test(16'h3C00, 16'hBC00, RNE, 16'h0000, ST_NONE);
    add_test(16'h3C00, 16'hBC00, RTZ, 16'h0000, ST_NONE);
    add_test(16'h3C00, 16'hBC00, RDN, 16'h8000, ST_NONE);
    add_test(16'h3C00, 16'hBC00, RUP, 16'h0000, ST_NONE);
    add_test(16'h3C00, 16'hBC00, RMM, 16'h0000, ST_NONE);
    // Largest finite doubled
    add_test(16'h7BFF, 16'h7BFF, RNE, 16'h7C00, ST_OF_NX);
    add_test(16'h7BFF, 16'h7BFF, RTZ, 16'h7BFF, ST_OF_NX);
    // NaN and infinity inputs
    add_test(16'h7E00, 16'h3C00, RNE, 16'h7E00, ST_NONE);
    add_test(16'h7C01, 16'h3C00, RNE, 16'h7E00, ST_NV);
    add_test(16'h7C00, 16'hFC00, RNE, 16'h7E00, ST_NV);
    add_test(16'hFC00, 16'h3C00, RNE, 16'hFC00, ST_NONE);
  endtask

  // Drive one table entry, it is sampled at the next rising edge
  task automatic apply_test(input int idx);
    operand_a_i = tests[idx].a;
    operand_b_i = tests[idx].b;
    rnd_mode_i  = tests[idx].mode;
    valid_i     = 1'b1;
    pend_idx_q.push_back(idx);
    pend_cycle_q.push_back(cycle_cnt);
  endtask

  // --------------------------------------------------
  // Compare and report
  task automatic check_result(input fp16_t got, input fp16_t want, inout bit ok);
    if (got !== want) begin
      $display("CHECK FAILED: result_o = %h, expected %h", got, want);
      ok = 1'b0;
    end
  endtask

  task automatic check_status(input status_t got, input status_t want, inout bit ok);
    if (got !== want) begin
      $display("CHECK FAILED: status_o = %h, expected %h", got, want);
      ok = 1'b0;
    end
  endtask

  task automatic report_test(input int idx, input bit ok);
    $display("test %0d %s: %h + %h mode %s", idx, ok ? "ok" : "FAILED",
             tests[idx].a, tests[idx].b, tests[idx].mode.name());
    if (ok) begin
      ok_cnt++;
    end else begin
      fail_cnt++;
    end
    done_cnt++;
  endtask

  task automatic score_output();
    int idx;
    int issued;
    bit ok;
    idx    = pend_idx_q.pop_front();
    issued = pend_cycle_q.pop_front();
    ok     = 1'b1;
    if (cycle_cnt - issued != LATENCY) begin
      $display("test %0d result came %0d cycles after its input, not %0d",
               idx, cycle_cnt - issued, LATENCY);
      ok = 1'b0;
    end
    check_result(result_o, tests[idx].result, ok);
    check_status(status_o, tests[idx].status, ok);
    report_test(idx, ok);
  endtask

  task automatic drop_missing();
    int idx;
    int issued;
    idx    = pend_idx_q.pop_front();
    issued = pend_cycle_q.pop_front();
    $display("test %0d driven in cycle %0d produced no valid_o %0d cycles later",
             idx, issued, LATENCY);
    report_test(idx, 1'b0);
  endtask

  // Outputs are sampled on the falling edge, clear of the register updates
  always @(negedge clk_i) begin
    if (valid_o) begin
      if (rst_i || (pend_idx_q.size() == 0)) begin
        $display("valid_o high at cycle %0d with no operation outstanding", cycle_cnt);
        other_errors++;
      end else begin
        score_output();
      end
    end else if ((pend_idx_q.size() != 0) && (cycle_cnt >= pend_cycle_q[0] + LATENCY)) begin
      drop_missing();
    end
  end

  // --------------------------------------------------
  // Main sequence
  initial begin
    clk_i       = 1'b0;
    rst_i       = 1'b1;
    valid_i     = 1'b0;
    operand_a_i = '0;
    operand_b_i = '0;
    rnd_mode_i  = RNE;
    load_table();
    repeat (3) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    // Idle cycles, valid_o must stay low before the first input
    repeat (3) @(posedge clk_i);
    #1;
    // Back to back, one operation per cycle
    for (int i = 0; i < NUM_TESTS; i++) begin
      apply_test(i);
      @(posedge clk_i);
      #1;
    end
    valid_i = 1'b0;
    wait (done_cnt == NUM_TESTS);
    repeat (4) @(posedge clk_i);
    $display("%0d tests, %0d ok, %0d failed, %0d other errors",
             NUM_TESTS, ok_cnt, fail_cnt, other_errors);
    if ((fail_cnt == 0) && (other_errors == 0)) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Watchdog, table length plus a margin of 100 cycles
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout after %0d ns with %0d of %0d tests finished",
             WATCHDOG_NS, done_cnt, NUM_TESTS);
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// File: fp16_adder.f
+incdir+src
src/fp16_pkg.sv
src/fp16_classifier.sv
src/fp16_special_cases.sv
src/fp16_align_add.sv
src/fp16_normalize.sv
src/fp16_round.sv
src/fp16_adder.sv
bench/fp16_adder_tb.sv

// File: Makefile
TOP := fp16_adder_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f fp16_adder.f --top-module $(TOP) -Mdir obj_dir

# The run fails unless the simulation output holds the pass message
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
